/* design/hazard_defines.svh */
// Widths are fixed to RV32I; pipeline depth counts fetch and decode, which are not shadowed
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Register index width, 32 integer registers
`define REG_IDX_W 5

// Major opcode field, instr[6:0]
`define OPCODE_W 7

// Stages in the classic pipeline
// Fetch, decode, execute, memory, writeback
`define PIPE_DEPTH 5

`endif

/* design/hazard_pkg.sv */
// Slot layout mirrors the decode fields only; no immediates or data travel with it
`include "hazard_defines.svh"

package hazard_pkg;

    import rv_isa_pkg::*;

    // One instruction as seen by the hazard logic
    // Used for the decode input and for the shadow slots
    typedef struct packed {
        logic                  valid;
        rv_opcode_e            opcode;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        // Cleared to zero in the shadow when the producer does not write rd
        logic [`REG_IDX_W-1:0] rd;
    } stage_slot_t;

    // Per-stage match result for each decode source
    typedef struct packed {
        logic hit_rs1;
        logic hit_rs2;
    } stage_hit_t;

    // Stage blamed for the current stall
    typedef enum logic [1:0] {
        src_none    = 2'd0,
        src_execute = 2'd1,
        src_memory  = 2'd2
    } stall_src_e;

endpackage

/* design/hazard_unit_top.sv */
// Stall is combinational from decode_slot; the caller holds decode_slot steady while stall is high
`include "hazard_defines.svh"

module hazard_unit_top
    import rv_isa_pkg::*;
    import hazard_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  stage_slot_t decode_slot,
    output logic        stall,
    output stall_src_e  stall_src,
    output stage_slot_t retire_slot
);

    // Sources and destination really used by the decode opcode
    operand_use_t decode_use;

    // Stored destinations, zero for non-writers and bubbles
    logic [`REG_IDX_W-1:0] ex_rd;
    logic [`REG_IDX_W-1:0] mem_rd;

    stage_hit_t ex_hit;
    stage_hit_t mem_hit;

    operand_use_decoder u_decoder (
        .opcode (decode_slot.opcode),
        .op_use (decode_use)
    );

    // Producer one instruction ahead
    stage_hazard_check u_ex_check (
        .decode_slot (decode_slot),
        .op_use      (decode_use),
        .stage_rd    (ex_rd),
        .hit         (ex_hit)
    );

    // Producer two instructions ahead
    stage_hazard_check u_mem_check (
        .decode_slot (decode_slot),
        .op_use      (decode_use),
        .stage_rd    (mem_rd),
        .hit         (mem_hit)
    );

    stall_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .decode_slot (decode_slot),
        .decode_use  (decode_use),
        .ex_hit      (ex_hit),
        .mem_hit     (mem_hit),
        .ex_rd       (ex_rd),
        .mem_rd      (mem_rd),
        .stall       (stall),
        .stall_src   (stall_src),
        .retire_slot (retire_slot)
    );

endmodule

/* design/operand_use_decoder.sv */
// Purely combinational; opcodes outside the RV32I base set read nothing and write nothing
module operand_use_decoder
    import rv_isa_pkg::*;
(
    input  rv_opcode_e   opcode,
    output operand_use_t op_use
);

    always_comb
    begin
        // Unknown opcode never takes part in a hazard
        op_use = '0;
        case (opcode)
            // R-type, both sources and a destination
            op_op:
            begin
                op_use = '{reads_rs1: 1'b1, reads_rs2: 1'b1, writes_rd: 1'b1};
            end
            // I-type ALU, loads and jalr use rs1 as base or operand
            op_op_imm, op_load, op_jalr:
            begin
                op_use = '{reads_rs1: 1'b1, reads_rs2: 1'b0, writes_rd: 1'b1};
            end
            // Store data comes from rs2, address base from rs1
            op_store:
            begin
                op_use = '{reads_rs1: 1'b1, reads_rs2: 1'b1, writes_rd: 1'b0};
            end
            // Compare of two registers, no result written
            op_branch:
            begin
                op_use = '{reads_rs1: 1'b1, reads_rs2: 1'b1, writes_rd: 1'b0};
            end
            // U-type and jal only produce a result
            op_jal, op_lui, op_auipc:
            begin
                op_use = '{reads_rs1: 1'b0, reads_rs2: 1'b0, writes_rd: 1'b1};
            end
            default:
            begin
                op_use = '0;
            end
        endcase
    end

endmodule

/* design/rv_isa_pkg.sv */
// Only the RV32I base major opcodes are known; funct3/funct7 and system opcodes are not decoded
`include "hazard_defines.svh"

package rv_isa_pkg;

    // Base major opcodes, instr[6:0]
    typedef enum logic [`OPCODE_W-1:0] {
        // Register-register ALU
        op_op     = 7'b0110011,
        // Register-immediate ALU
        op_op_imm = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } rv_opcode_e;

    // Which register fields an instruction really touches
    typedef struct packed {
        // rs1 is a true source
        logic reads_rs1;
        // rs2 is a true source
        logic reads_rs2;
        // rd is written at writeback
        logic writes_rd;
    } operand_use_t;

endpackage

/* design/stage_hazard_check.sv */
// Combinational compare against one stage; stage_rd must already be zero for non-writers
`include "hazard_defines.svh"

module stage_hazard_check
    import rv_isa_pkg::*;
    import hazard_pkg::*;
(
    input  stage_slot_t           decode_slot,
    input  operand_use_t          op_use,
    input  logic [`REG_IDX_W-1:0] stage_rd,
    output stage_hit_t            hit
);

    // x0 is hardwired, writing it never creates a dependency
    logic rd_live;

    // Raw index matches before qualification
    logic rs1_match;
    logic rs2_match;

    assign rd_live = (stage_rd != '0);

    assign rs1_match = (decode_slot.rs1 == stage_rd);
    assign rs2_match = (decode_slot.rs2 == stage_rd);

    // A field only counts when the opcode really reads it
    // Immediate bits sitting in rs2 for I-type must not match
    assign hit.hit_rs1 = decode_slot.valid
                       & op_use.reads_rs1
                       & rd_live
                       & rs1_match;

    assign hit.hit_rs2 = decode_slot.valid
                       & op_use.reads_rs2
                       & rd_live
                       & rs2_match;

endmodule

/* design/stall_sequencer.sv */
// No forwarding or flush; decode must hold its slot while stall is high, reset is synchronous
`include "hazard_defines.svh"

module stall_sequencer
    import rv_isa_pkg::*;
    import hazard_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  stage_slot_t           decode_slot,
    input  operand_use_t          decode_use,
    input  stage_hit_t            ex_hit,
    input  stage_hit_t            mem_hit,
    output logic [`REG_IDX_W-1:0] ex_rd,
    output logic [`REG_IDX_W-1:0] mem_rd,
    output logic                  stall,
    output stall_src_e            stall_src,
    output stage_slot_t           retire_slot
);

    // Fetch and decode are not shadowed
    localparam int SHADOW_N = `PIPE_DEPTH - 2;
    localparam int EX_IDX = 0;
    localparam int MEM_IDX = 1;
    localparam int WB_IDX = SHADOW_N - 1;

    // Shadow slots, index 0 is execute, last is writeback
    stage_slot_t shadow [SHADOW_N];

    // Named views of the shadow
    stage_slot_t ex_slot;
    stage_slot_t mem_slot;
    stage_slot_t wb_slot;

    // Any source matching per stage
    logic ex_any;
    logic mem_any;

    // Decode moves into execute this edge
    logic issue;

    // Slot that execute takes on issue
    stage_slot_t issue_slot;

    assign ex_any  = ex_hit.hit_rs1 | ex_hit.hit_rs2;
    assign mem_any = mem_hit.hit_rs1 | mem_hit.hit_rs2;

    // Hits are already qualified by the decode valid bit
    assign stall = ex_any | mem_any;

    // Execute wins, its producer is the younger one and stalls longer
    always_comb
    begin
        if (ex_any)
        begin
            stall_src = src_execute;
        end
        else if (mem_any)
        begin
            stall_src = src_memory;
        end
        else
        begin
            stall_src = src_none;
        end
    end

    assign issue = decode_slot.valid & ~stall;

    // Non-writers carry rd zero so later checks ignore them
    always_comb
    begin
        issue_slot = decode_slot;
        if (!decode_use.writes_rd)
        begin
            issue_slot.rd = '0;
        end
    end

    // Older slots advance every cycle, a stall only bubbles execute
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < SHADOW_N; i++)
            begin
                shadow[i] <= '0;
            end
        end
        else
        begin
            for (int i = SHADOW_N - 1; i > 0; i--)
            begin
                shadow[i] <= shadow[i-1];
            end
            // Bubble is all zero, valid low and rd zero
            shadow[EX_IDX] <= issue ? issue_slot : stage_slot_t'('0);
        end
    end

    assign ex_slot  = shadow[EX_IDX];
    assign mem_slot = shadow[MEM_IDX];
    assign wb_slot  = shadow[WB_IDX];

    assign ex_rd       = ex_slot.rd;
    assign mem_rd      = mem_slot.rd;
    // A producer in writeback no longer blocks decode
    assign retire_slot = wb_slot;

endmodule

/* list.f */
+incdir+design
design/rv_isa_pkg.sv
design/hazard_pkg.sv
design/operand_use_decoder.sv
design/stage_hazard_check.sv
design/stall_sequencer.sv
design/hazard_unit_top.sv
tests/hazard_unit_assertions.sv
tests/hazard_unit_tb.sv

/* tests/hazard_unit_assertions.sv */
// Stall rules seen at the sequencer; all properties are disabled while reset is high
module hazard_unit_assertions
    import hazard_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input stage_slot_t decode_slot,
    input logic        stall,
    input stall_src_e  stall_src,
    input stage_slot_t ex_slot
);

    // Number of property failures so far
    int fail_count = 0;

    // Nothing to hold back when decode is empty
    stall_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        stall |-> decode_slot.valid
    )
    else
    begin
        fail_count++;
        $error("stall high while the decode slot is empty");
    end

    // Source names a stage exactly when stalling
    src_matches_stall: assert property (
        @(posedge clk) disable iff (reset)
        (stall_src == src_none) == !stall
    )
    else
    begin
        fail_count++;
        $error("stall_src disagrees with stall");
    end

    // Stalled decode leaves a bubble in execute
    bubble_after_stall: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> (!ex_slot.valid && ex_slot.rd == '0)
    )
    else
    begin
        fail_count++;
        $error("execute slot is not a bubble after a stalled cycle");
    end

    // Worst case is a producer in execute, two cycles
    stall_at_most_two: assert property (
        @(posedge clk) disable iff (reset)
        (stall && $past(stall)) |=> !stall
    )
    else
    begin
        fail_count++;
        $error("stall held for more than two cycles");
    end

endmodule

// Attach to every sequencer instance
bind stall_sequencer hazard_unit_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .decode_slot (decode_slot),
    .stall       (stall),
    .stall_src   (stall_src),
    .ex_slot     (ex_slot)
);

/* tests/hazard_unit_tb.sv */
// Expected values are worked out by hand per cycle row; rows assume an empty pipeline after reset
`include "hazard_defines.svh"

module hazard_unit_tb
    import rv_isa_pkg::*;
    import hazard_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam int ROW_COUNT = 52;
    localparam int GROUP_COUNT = 6;
    // Slack for reset release and the closing report
    localparam int MARGIN_CYCLES = 20;

    // One cycle of stimulus with the responses expected in that cycle
    typedef struct packed {
        logic [2:0]            group;
        stage_slot_t           slot;
        logic                  stall;
        stall_src_e            src;
        logic                  ret_valid;
        logic [`REG_IDX_W-1:0] ret_rd;
    } row_t;

    logic        clk;
    logic        reset;
    stage_slot_t decode_slot;
    logic        stall;
    stall_src_e  stall_src;
    stage_slot_t retire_slot;

    row_t  rows [ROW_COUNT];
    int    row_fill;
    int    error_count;
    int    check_count;
    int    assert_failures;
    int    group_errors;
    int    group_rows;
    string group_names [GROUP_COUNT];

    hazard_unit_top uut (
        .clk         (clk),
        .reset       (reset),
        .decode_slot (decode_slot),
        .stall       (stall),
        .stall_src   (stall_src),
        .retire_slot (retire_slot)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    task automatic check_value(
        input int          row,
        input string       name,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            group_errors++;
            $display("MISMATCH row %0d %s got 0x%0h expected 0x%0h", row, name, got, expected);
        end
    endtask

    // Valid decode instruction and the responses for its cycle
    task automatic add_row(
        input int         grp,
        input rv_opcode_e op,
        input int         rs1,
        input int         rs2,
        input int         rd,
        input logic       exp_stall,
        input stall_src_e exp_src,
        input logic       exp_ret_valid,
        input int         exp_ret_rd
    );
        row_t r;
        r.group = grp[2:0];
        r.slot.valid = 1'b1;
        r.slot.opcode = op;
        r.slot.rs1 = rs1[`REG_IDX_W-1:0];
        r.slot.rs2 = rs2[`REG_IDX_W-1:0];
        r.slot.rd = rd[`REG_IDX_W-1:0];
        r.stall = exp_stall;
        r.src = exp_src;
        r.ret_valid = exp_ret_valid;
        r.ret_rd = exp_ret_rd[`REG_IDX_W-1:0];
        if (row_fill < ROW_COUNT)
        begin
            rows[row_fill] = r;
        end
        row_fill++;
    endtask

    // Empty decode cycle, only the retire side is expected to move
    task automatic add_idle(input int grp, input logic exp_ret_valid, input int exp_ret_rd);
        row_t r;
        r = '0;
        r.group = grp[2:0];
        r.slot.opcode = op_op;
        // Stale fields name the last destination, only valid keeps them out
        if (row_fill > 0 && row_fill <= ROW_COUNT)
        begin
            r.slot.rs1 = rows[row_fill-1].slot.rd;
            r.slot.rs2 = rows[row_fill-1].slot.rd;
            r.slot.rd = rows[row_fill-1].slot.rd;
        end
        r.src = src_none;
        r.ret_valid = exp_ret_valid;
        r.ret_rd = exp_ret_rd[`REG_IDX_W-1:0];
        if (row_fill < ROW_COUNT)
        begin
            rows[row_fill] = r;
        end
        row_fill++;
    endtask

    task automatic fill_table();
        // Retire columns show the instruction issued three rows earlier
        add_idle(0, 1'b0, 0);
        // Load then dependent ALU op, producer first in execute then in memory
        add_row(1, op_load, 1, 0, 5, 1'b0, src_none, 1'b0, 0);
        add_row(1, op_op, 5, 2, 6, 1'b1, src_execute, 1'b0, 0);
        add_row(1, op_op, 5, 2, 6, 1'b1, src_memory, 1'b0, 0);
        add_row(1, op_op, 5, 2, 6, 1'b0, src_none, 1'b1, 5);
        add_idle(1, 1'b0, 0);
        add_idle(1, 1'b0, 0);
        add_idle(1, 1'b1, 6);
        // Producer two ahead, lui in between
        add_row(2, op_op_imm, 1, 0, 7, 1'b0, src_none, 1'b0, 0);
        add_row(2, op_lui, 0, 0, 8, 1'b0, src_none, 1'b0, 0);
        add_row(2, op_op, 7, 3, 9, 1'b1, src_memory, 1'b0, 0);
        add_row(2, op_op, 7, 3, 9, 1'b0, src_none, 1'b1, 7);
        // Store reads the produced value through rs2 only
        add_row(2, op_op_imm, 1, 0, 10, 1'b0, src_none, 1'b1, 8);
        add_row(2, op_lui, 0, 0, 11, 1'b0, src_none, 1'b0, 0);
        add_row(2, op_store, 2, 10, 3, 1'b1, src_memory, 1'b1, 9);
        add_row(2, op_store, 2, 10, 3, 1'b0, src_none, 1'b1, 10);
        // jalr base register two ahead
        add_row(2, op_op, 1, 2, 12, 1'b0, src_none, 1'b1, 11);
        add_row(2, op_auipc, 0, 0, 13, 1'b0, src_none, 1'b0, 0);
        add_row(2, op_jalr, 12, 0, 1, 1'b1, src_memory, 1'b1, 0);
        add_row(2, op_jalr, 12, 0, 1, 1'b0, src_none, 1'b1, 12);
        add_idle(2, 1'b1, 13);
        add_idle(2, 1'b0, 0);
        add_idle(2, 1'b1, 1);
        // Producer writes x0
        add_row(3, op_op, 1, 2, 0, 1'b0, src_none, 1'b0, 0);
        add_row(3, op_op, 0, 0, 14, 1'b0, src_none, 1'b0, 0);
        // Store and branch carry immediate bits in rd, stored as zero
        add_row(3, op_store, 3, 4, 15, 1'b0, src_none, 1'b0, 0);
        add_row(3, op_op, 15, 2, 16, 1'b0, src_none, 1'b1, 0);
        add_row(3, op_branch, 1, 2, 17, 1'b0, src_none, 1'b1, 14);
        add_row(3, op_op, 17, 17, 18, 1'b0, src_none, 1'b1, 0);
        // lui and jal ignore whatever sits in their source fields
        add_row(3, op_op_imm, 1, 0, 19, 1'b0, src_none, 1'b1, 16);
        add_row(3, op_lui, 19, 19, 20, 1'b0, src_none, 1'b1, 0);
        add_row(3, op_jal, 19, 20, 21, 1'b0, src_none, 1'b1, 18);
        // x19 producer has reached writeback
        add_row(3, op_op, 19, 2, 22, 1'b0, src_none, 1'b1, 19);
        add_idle(3, 1'b1, 20);
        add_idle(3, 1'b1, 21);
        add_idle(3, 1'b1, 22);
        // rs2 on execute and rs1 on memory at once
        add_row(4, op_load, 1, 0, 23, 1'b0, src_none, 1'b0, 0);
        add_row(4, op_load, 1, 0, 24, 1'b0, src_none, 1'b0, 0);
        add_row(4, op_op, 23, 24, 25, 1'b1, src_execute, 1'b0, 0);
        add_row(4, op_op, 23, 24, 25, 1'b1, src_memory, 1'b1, 23);
        add_row(4, op_op, 23, 24, 25, 1'b0, src_none, 1'b1, 24);
        // Branch blocked through rs2
        add_row(4, op_op_imm, 1, 0, 26, 1'b0, src_none, 1'b0, 0);
        add_row(4, op_branch, 2, 26, 0, 1'b1, src_execute, 1'b0, 0);
        add_row(4, op_branch, 2, 26, 0, 1'b1, src_memory, 1'b1, 25);
        add_row(4, op_branch, 2, 26, 0, 1'b0, src_none, 1'b1, 26);
        // Branch blocked through rs1
        add_row(4, op_auipc, 0, 0, 27, 1'b0, src_none, 1'b0, 0);
        add_row(4, op_branch, 27, 3, 0, 1'b1, src_execute, 1'b0, 0);
        add_row(4, op_branch, 27, 3, 0, 1'b1, src_memory, 1'b1, 0);
        add_row(4, op_branch, 27, 3, 0, 1'b0, src_none, 1'b1, 27);
        // Drain, last branch retires with rd zero
        add_idle(5, 1'b0, 0);
        add_idle(5, 1'b0, 0);
        add_idle(5, 1'b1, 0);
    endtask

    task automatic report_group(input int grp);
        $display("group %0d %s: %0d rows, %0d mismatches",
                 grp, group_names[grp], group_rows, group_errors);
        group_rows = 0;
        group_errors = 0;
    endtask

    initial
    begin
        error_count = 0;
        check_count = 0;
        assert_failures = 0;
        group_errors = 0;
        group_rows = 0;
        row_fill = 0;
        reset = 1'b1;
        decode_slot = '0;
        group_names[0] = "after reset";
        group_names[1] = "execute hazard";
        group_names[2] = "memory hazard";
        group_names[3] = "no hazard";
        group_names[4] = "double hazard and branch";
        group_names[5] = "retire drain";
        fill_table();
        if (row_fill != ROW_COUNT)
        begin
            error_count++;
            $display("Stimulus table holds %0d rows but %0d were expected", row_fill, ROW_COUNT);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < ROW_COUNT; i++)
        begin
            if (i > 0 && rows[i].group != rows[i-1].group)
            begin
                report_group(rows[i-1].group);
            end
            decode_slot = rows[i].slot;
            // Sample mid cycle, combinational outputs have settled
            #2;
            check_value(i, "stall", stall, rows[i].stall);
            check_value(i, "stall_src", stall_src, rows[i].src);
            check_value(i, "retire_slot.valid", retire_slot.valid, rows[i].ret_valid);
            check_value(i, "retire_slot.rd", retire_slot.rd, rows[i].ret_rd);
            group_rows++;
            @(posedge clk);
            #1;
        end
        report_group(rows[ROW_COUNT-1].group);
        // Each bound property failure has already printed its own error line
        assert_failures = uut.u_sequencer.u_assertions.fail_count;
        error_count += assert_failures;
        $display("rows %0d, checks %0d, assertion failures %0d, errors %0d",
                 ROW_COUNT, check_count, assert_failures, error_count);
        if (error_count == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #((ROW_COUNT + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d time units",
                 (ROW_COUNT + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Errors found");
        $finish;
    end

endmodule
